// File: hdl/sifh_cfg.svh
`ifndef SIFH_CFG_SVH
`define SIFH_CFG_SVH

// timestamp width from the front end
`define SIFH_TS_W 12
// bin index width, same for coarse and fine histograms
`define SIFH_BIN_W 4
// bins per histogram
`define SIFH_BINS 16
// bin counter width, counts saturate at all ones
`define SIFH_CNT_W 5
// samples per pass
`define SIFH_FRAME_LEN 64
// pass sample counter width, must hold SIFH_FRAME_LEN
`define SIFH_FRAME_W 7
// max credits outstanding at the sender
`define SIFH_CREDITS 2
// outstanding credit counter width
`define SIFH_CREDIT_W 2

`endif

// File: hdl/sifhPkg.sv
`include "sifh_cfg.svh"

package sifhPkg;

    // raw timestamp from the front end
    typedef logic [`SIFH_TS_W-1:0] tsT;

    // histogram bin address
    typedef logic [`SIFH_BIN_W-1:0] binIdxT;

    // per-bin hit count
    typedef logic [`SIFH_CNT_W-1:0] cntT;

    // samples taken in the current pass
    typedef logic [`SIFH_FRAME_W-1:0] frameCntT;

    // credits granted but not yet spent
    typedef logic [`SIFH_CREDIT_W-1:0] creditCntT;

    // controller states, shared by coarse and fine pass
    typedef enum logic [2:0] {
        sIdle, sClear, sAcq, sDrain, sScan, sWindow, sReport
    } stateT;

endpackage

// File: hdl/binMapper.sv
`include "sifh_cfg.svh"

module binMapper (
    input  logic            clk,
    input  logic            rstN,
    input  logic            sampleValid,
    input  sifhPkg::tsT     sample,
    input  logic            pass,
    input  logic            acqEn,
    input  sifhPkg::tsT     thMinus,
    output logic            binValid,
    output sifhPkg::binIdxT binIdx
);
    sifhPkg::tsT     offset;
    logic            inWindow;
    sifhPkg::binIdxT mappedIdx;

    // offset from the lower window bound, only meaningful when sample >= thMinus
    assign offset = sample - thMinus;
    // window is one coarse bin wide, so the top offset bits must be zero
    assign inWindow = (sample >= thMinus)
        && (offset[`SIFH_TS_W-1 -: `SIFH_BIN_W] == '0);

    // coarse: top bits of the stamp
    // fine: next bits of the offset, 16 counts per bin
    assign mappedIdx = pass ? offset[`SIFH_TS_W-`SIFH_BIN_W-1 -: `SIFH_BIN_W]
                            : sample[`SIFH_TS_W-1 -: `SIFH_BIN_W];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            binValid <= 1'b0;
        end else begin
            // out-of-window fine samples are dropped here
            binValid <= sampleValid && acqEn && (!pass || inWindow);
        end
    end

    // index only matters while binValid is high
    always_ff @(posedge clk) begin
        binIdx <= mappedIdx;
    end

endmodule

// File: hdl/windowCalc.sv
`include "sifh_cfg.svh"

module windowCalc (
    input  logic            clk,
    input  logic            rstN,
    input  logic            winLoad,
    input  sifhPkg::binIdxT peakIdx,
    output sifhPkg::tsT     thMinus
);
    // coarse bin span, 256 counts
    localparam int CoarseW = 1 << (`SIFH_TS_W - `SIFH_BIN_W);
    // window opens half a coarse bin below the peak bin
    localparam int HalfW = CoarseW / 2;
    // highest lower bound that keeps the whole window in range
    localparam int MaxLow = (1 << `SIFH_TS_W) - CoarseW;

    logic signed [`SIFH_TS_W+1:0] lowRaw;
    sifhPkg::tsT                  lowClip;

    // peak bin start minus half a bin, may go negative for bin 0
    assign lowRaw = $signed({2'b00, peakIdx, {(`SIFH_TS_W-`SIFH_BIN_W){1'b0}}})
        - (`SIFH_TS_W+2)'(HalfW);

    always_comb begin
        if (lowRaw < 0) begin
            lowClip = '0;
        end else if (lowRaw > (`SIFH_TS_W+2)'(MaxLow)) begin
            lowClip = sifhPkg::tsT'(MaxLow);
        end else begin
            lowClip = lowRaw[`SIFH_TS_W-1:0];
        end
    end

    // held until the next coarse pass finishes
    always_ff @(posedge clk) begin
        if (!rstN) begin
            thMinus <= '0;
        end else if (winLoad) begin
            thMinus <= lowClip;
        end
    end

endmodule

// File: hdl/histogramRam.sv
`include "sifh_cfg.svh"

module histogramRam (
    input  logic            clk,
    input  logic            rstN,
    input  logic            clearEn,
    input  sifhPkg::binIdxT clearAddr,
    input  logic            binValid,
    input  sifhPkg::binIdxT binIdx,
    input  logic            rdEn,
    input  sifhPkg::binIdxT rdAddr,
    output logic            rdValid,
    output sifhPkg::binIdxT rdIdx,
    output sifhPkg::cntT    rdCount
);
    sifhPkg::cntT    mem [`SIFH_BINS];

    // write stage of the read-modify-write
    logic            hitValid;
    sifhPkg::binIdxT hitIdx;
    sifhPkg::cntT    hitCnt;

    sifhPkg::cntT    hitNext;
    sifhPkg::cntT    readCnt;

    // saturating increment, sticks at 31
    assign hitNext = (hitCnt == '1) ? hitCnt : hitCnt + 1'b1;

    // same bin in the write stage: take the value being written,
    // memory still holds the old count on this edge
    assign readCnt = (hitValid && (hitIdx == binIdx)) ? hitNext : mem[binIdx];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hitValid <= 1'b0;
            rdValid  <= 1'b0;
        end else begin
            hitValid <= binValid;
            rdValid  <= rdEn;
        end
    end

    // read stage for hits
    always_ff @(posedge clk) begin
        hitIdx <= binIdx;
        hitCnt <= readCnt;
    end

    // readout port, one cycle latency, index travels with count
    always_ff @(posedge clk) begin
        rdIdx   <= rdAddr;
        rdCount <= mem[rdAddr];
    end

    // clear and hits never overlap, clear wins anyway
    always_ff @(posedge clk) begin
        if (clearEn) begin
            mem[clearAddr] <= '0;
        end else if (hitValid) begin
            mem[hitIdx] <= hitNext;
        end
    end

endmodule

// File: hdl/peakDetector.sv
`include "sifh_cfg.svh"

module peakDetector (
    input  logic            clk,
    input  logic            rstN,
    input  logic            scanStart,
    input  logic            rdValid,
    input  sifhPkg::binIdxT rdIdx,
    input  sifhPkg::cntT    rdCount,
    output logic            peakDone,
    output sifhPkg::binIdxT peakIdx,
    output sifhPkg::cntT    peakCnt
);
    logic lastBin;
    logic newMax;

    // readout always ends on the top bin
    assign lastBin = rdValid && (rdIdx == sifhPkg::binIdxT'(`SIFH_BINS - 1));

    // strictly greater, so on a tie the lower index stays
    assign newMax = rdValid && (rdCount > peakCnt);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakDone <= 1'b0;
        end else begin
            // max already includes bin 15 when this goes high
            peakDone <= lastBin;
        end
    end

    // running max, held after the scan for the report
    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakIdx <= '0;
            peakCnt <= '0;
        end else if (scanStart) begin
            peakIdx <= '0;
            peakCnt <= '0;
        end else if (newMax) begin
            peakIdx <= rdIdx;
            peakCnt <= rdCount;
        end
    end

endmodule

// File: hdl/hisBuilderFsm.sv
`include "sifh_cfg.svh"

module hisBuilderFsm (
    input  logic            clk,
    input  logic            rstN,
    input  logic            start,
    input  logic            sampleValid,
    input  logic            peakDone,
    output logic            creditOut,
    output logic            busy,
    output logic            pass,
    output logic            acqEn,
    output logic            clearEn,
    output sifhPkg::binIdxT clearAddr,
    output logic            rdEn,
    output sifhPkg::binIdxT rdAddr,
    output logic            scanStart,
    output logic            winLoad,
    output logic            resultValid
);
    sifhPkg::stateT     state;

    // shared address counter for clear and scan
    sifhPkg::binIdxT    binCnt;

    // credit bookkeeping for the current pass
    sifhPkg::creditCntT outstanding;
    sifhPkg::frameCntT  issued;
    sifhPkg::frameCntT  accepted;

    logic               drainCnt;
    logic               scanIssued;
    logic               accept;
    logic               inAcq;

    assign inAcq = (state == sifhPkg::sAcq);

    // mapper takes a sample only against a credit still held by the sender
    assign acqEn = inAcq && (outstanding != '0);

    // one grant per cycle while the window and the frame allow it
    assign creditOut = inAcq
        && (outstanding < sifhPkg::creditCntT'(`SIFH_CREDITS))
        && (issued < sifhPkg::frameCntT'(`SIFH_FRAME_LEN));

    // samples without a credit behind them are ignored
    assign accept = acqEn && sampleValid;

    assign clearEn   = (state == sifhPkg::sClear);
    assign clearAddr = binCnt;

    assign rdEn   = (state == sifhPkg::sScan) && !scanIssued;
    assign rdAddr = binCnt;

    // last drain cycle, ahead of the first readout
    assign scanStart = (state == sifhPkg::sDrain) && drainCnt;

    assign winLoad     = (state == sifhPkg::sWindow);
    assign resultValid = (state == sifhPkg::sReport);
    assign busy        = (state != sifhPkg::sIdle);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state       <= sifhPkg::sIdle;
            pass        <= 1'b0;
            binCnt      <= '0;
            outstanding <= '0;
            issued      <= '0;
            accepted    <= '0;
            drainCnt    <= 1'b0;
            scanIssued  <= 1'b0;
        end else begin
            case (state)
                sifhPkg::sIdle: begin
                    if (start) begin
                        state  <= sifhPkg::sClear;
                        pass   <= 1'b0;
                        binCnt <= '0;
                    end
                end
                // one bin per cycle, wraps back to 0 for the scan later
                sifhPkg::sClear: begin
                    binCnt <= binCnt + 1'b1;
                    if (binCnt == sifhPkg::binIdxT'(`SIFH_BINS - 1)) begin
                        state       <= sifhPkg::sAcq;
                        outstanding <= '0;
                        issued      <= '0;
                        accepted    <= '0;
                    end
                end
                sifhPkg::sAcq: begin
                    // a spent credit is returned on the next cycle
                    outstanding <= outstanding + sifhPkg::creditCntT'(creditOut)
                        - sifhPkg::creditCntT'(accept);
                    issued <= issued + sifhPkg::frameCntT'(creditOut);
                    if (accept) begin
                        accepted <= accepted + 1'b1;
                    end
                    // last sample of the frame ends the pass
                    if (accept && (accepted == sifhPkg::frameCntT'(`SIFH_FRAME_LEN - 1))) begin
                        state    <= sifhPkg::sDrain;
                        drainCnt <= 1'b0;
                    end
                end
                // two cycles for mapper and RAM write stage to empty
                sifhPkg::sDrain: begin
                    drainCnt <= 1'b1;
                    if (drainCnt) begin
                        state      <= sifhPkg::sScan;
                        binCnt     <= '0;
                        scanIssued <= 1'b0;
                    end
                end
                sifhPkg::sScan: begin
                    if (rdEn) begin
                        binCnt <= binCnt + 1'b1;
                        if (binCnt == sifhPkg::binIdxT'(`SIFH_BINS - 1)) begin
                            scanIssued <= 1'b1;
                        end
                    end
                    if (peakDone) begin
                        state <= pass ? sifhPkg::sReport : sifhPkg::sWindow;
                    end
                end
                // window latched this cycle, fine pass follows
                sifhPkg::sWindow: begin
                    pass   <= 1'b1;
                    binCnt <= '0;
                    state  <= sifhPkg::sClear;
                end
                sifhPkg::sReport: begin
                    state <= sifhPkg::sIdle;
                end
                default: begin
                    state <= sifhPkg::sIdle;
                end
            endcase
        end
    end

endmodule

// File: hdl/sifhTop.sv
`include "sifh_cfg.svh"

module sifhTop (
    input  logic            clk,
    input  logic            rstN,
    input  logic            start,
    input  logic            sampleValid,
    input  sifhPkg::tsT     sample,
    output logic            creditOut,
    output logic            busy,
    output logic            resultValid,
    output sifhPkg::binIdxT peakCoarse,
    output sifhPkg::binIdxT peakFine,
    output sifhPkg::cntT    peakCount,
    output sifhPkg::tsT     tsEstimate
);
    // half a coarse bin, undoes the window offset
    localparam int HalfCoarse = (1 << (`SIFH_TS_W - `SIFH_BIN_W)) / 2;
    // fine bin width and its centre
    localparam int FineShift = `SIFH_TS_W - 2 * `SIFH_BIN_W;
    localparam int HalfFine  = (1 << FineShift) / 2;

    logic            pass;
    logic            acqEn;
    logic            clearEn;
    sifhPkg::binIdxT clearAddr;
    logic            rdEn;
    sifhPkg::binIdxT rdAddr;
    logic            scanStart;
    logic            winLoad;
    logic            binValid;
    sifhPkg::binIdxT binIdx;
    logic            rdValid;
    sifhPkg::binIdxT rdIdx;
    sifhPkg::cntT    rdCount;
    logic            peakDone;
    sifhPkg::binIdxT peakIdx;
    sifhPkg::cntT    peakCnt;
    sifhPkg::tsT     thMinus;
    sifhPkg::tsT     thCentre;

    hisBuilderFsm u_hisBuilderFsm (
        .clk(clk), .rstN(rstN), .start(start), .sampleValid(sampleValid),
        .peakDone(peakDone), .creditOut(creditOut), .busy(busy), .pass(pass),
        .acqEn(acqEn), .clearEn(clearEn), .clearAddr(clearAddr), .rdEn(rdEn),
        .rdAddr(rdAddr), .scanStart(scanStart), .winLoad(winLoad),
        .resultValid(resultValid)
    );

    binMapper u_binMapper (
        .clk(clk), .rstN(rstN), .sampleValid(sampleValid), .sample(sample),
        .pass(pass), .acqEn(acqEn), .thMinus(thMinus), .binValid(binValid),
        .binIdx(binIdx)
    );

    histogramRam u_histogramRam (
        .clk(clk), .rstN(rstN), .clearEn(clearEn), .clearAddr(clearAddr),
        .binValid(binValid), .binIdx(binIdx), .rdEn(rdEn), .rdAddr(rdAddr),
        .rdValid(rdValid), .rdIdx(rdIdx), .rdCount(rdCount)
    );

    peakDetector u_peakDetector (
        .clk(clk), .rstN(rstN), .scanStart(scanStart), .rdValid(rdValid),
        .rdIdx(rdIdx), .rdCount(rdCount), .peakDone(peakDone),
        .peakIdx(peakIdx), .peakCnt(peakCnt)
    );

    windowCalc u_windowCalc (
        .clk(clk), .rstN(rstN), .winLoad(winLoad), .peakIdx(peakIdx),
        .thMinus(thMinus)
    );

    // coarse peak recovered from the latched bound, the clip at 0 still maps to bin 0
    assign thCentre   = thMinus + sifhPkg::tsT'(HalfCoarse);
    assign peakCoarse = thCentre[`SIFH_TS_W-1 -: `SIFH_BIN_W];

    assign peakFine  = peakIdx;
    assign peakCount = peakCnt;

    // centre of the fine peak bin
    assign tsEstimate = thMinus + (sifhPkg::tsT'(peakIdx) << FineShift)
        + sifhPkg::tsT'(HalfFine);

endmodule

// File: bench/sifhTb.sv
`include "sifh_cfg.svh"

module sifhTb;
    localparam int Bins      = `SIFH_BINS;
    localparam int FrameLen  = `SIFH_FRAME_LEN;
    localparam int MaxCnt    = (1 << `SIFH_CNT_W) - 1;
    // coarse and fine bin spans in timestamp counts
    localparam int CoarseW   = 1 << (`SIFH_TS_W - `SIFH_BIN_W);
    localparam int FineW     = CoarseW / Bins;
    localparam int TopLow    = (1 << `SIFH_TS_W) - CoarseW;
    localparam int WaitLimit = 2000;

    logic            clk;
    logic            rstN;
    logic            start;
    logic            sampleValid;
    sifhPkg::tsT     sample;
    logic            creditOut;
    logic            busy;
    logic            resultValid;
    sifhPkg::binIdxT peakCoarse;
    sifhPkg::binIdxT peakFine;
    sifhPkg::cntT    peakCount;
    sifhPkg::tsT     tsEstimate;

    logic [31:0]     rngState;
    // one frame, sent once per pass
    sifhPkg::tsT     frame [FrameLen];
    // reference histograms
    int              coarseHist [Bins];
    int              fineHist [Bins];

    sifhTop u_sifhTop (
        .clk(clk), .rstN(rstN), .start(start), .sampleValid(sampleValid),
        .sample(sample), .creditOut(creditOut), .busy(busy),
        .resultValid(resultValid), .peakCoarse(peakCoarse), .peakFine(peakFine),
        .peakCount(peakCount), .tsEstimate(tsEstimate)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stopRun(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic valueError(input string msg);
        stopRun($sformatf("ERROR %0t: %s", $time, msg));
    endtask

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // first bin with the highest count, lowest index on a tie
    function automatic int firstMax(input bit fine);
        int best;
        int idx;
        int c;
        best = 0;
        idx = 0;
        for (int b = 0; b < Bins; b++) begin
            c = fine ? fineHist[b] : coarseHist[b];
            if (c > best) begin
                best = c;
                idx = b;
            end
        end
        return idx;
    endfunction

    task automatic buildFrame(input int kind);
        logic [31:0] r;
        for (int i = 0; i < FrameLen; i++) begin
            r = nextRand();
            frame[i] = r[11:0];
            case (kind)
                // cluster inside coarse bin 9
                0: if (i % 3 == 0) frame[i] = {5'b10010, r[18:12]};
                // 30 hits each in bins 2 and 11, bin 2 must win
                1: frame[i] = (i < 60) ? {((i % 2 == 0) ? 4'h2 : 4'hb), r[19:12]}
                                      : {4'h5, r[19:12]};
                // cluster under 64, lower bound clips to 0
                2: if (i % 2 == 0) frame[i] = {6'b0, r[17:12]};
                // 40 hits on one value, count sticks at the top
                3: if (i < 40) frame[i] = 12'h705;
                // 20 hits in a row, rest kept far below the window
                default: frame[i] = (i < 20) ? 12'ha37 : {1'b0, r[10:0]};
            endcase
        end
    endtask

    task automatic runModel(output int expCoarse, output int expFine,
                            output int expCount, output int expEst);
        int b;
        int low;
        int ts;
        for (b = 0; b < Bins; b++) begin
            coarseHist[b] = 0;
            fineHist[b] = 0;
        end
        for (int i = 0; i < FrameLen; i++) begin
            b = frame[i] / CoarseW;
            if (coarseHist[b] < MaxCnt) coarseHist[b]++;
        end
        expCoarse = firstMax(1'b0);
        // half a coarse bin below the peak bin start, kept in range
        low = expCoarse * CoarseW - CoarseW / 2;
        if (low < 0) low = 0;
        if (low > TopLow) low = TopLow;
        for (int i = 0; i < FrameLen; i++) begin
            ts = frame[i];
            if (ts >= low && ts < low + CoarseW) begin
                b = (ts - low) / FineW;
                if (fineHist[b] < MaxCnt) fineHist[b]++;
            end
        end
        expFine = firstMax(1'b1);
        expCount = fineHist[expFine];
        expEst = low + expFine * FineW + FineW / 2;
    endtask

    // one pass worth of samples, called just after a rising edge
    task automatic sendFrame(input bit fast);
        int sent;
        int grants;
        int credits;
        int idle;
        int guard;
        logic grantNow;
        logic [31:0] r;
        sent = 0;
        grants = 0;
        credits = 0;
        idle = 0;
        guard = 0;
        grantNow = creditOut;
        while (sent < FrameLen) begin
            // only credits already held may be spent
            if (credits > 0 && idle == 0) begin
                sampleValid = 1'b1;
                sample = frame[sent];
            end else begin
                sampleValid = 1'b0;
            end
            if (idle > 0) idle--;
            @(posedge clk);
            if (grantNow) begin
                credits++;
                grants++;
            end
            if (sampleValid) begin
                credits--;
                sent++;
                r = nextRand();
                idle = (fast || r[0]) ? 0 : int'(r[2:1]) + 1;
            end
            assert (credits >= 0 && credits <= `SIFH_CREDITS)
                else valueError($sformatf("sender holds %0d credits", credits));
            guard++;
            if (guard > WaitLimit) stopRun("credits for the frame never arrived");
            #10;
            grantNow = creditOut;
        end
        sampleValid = 1'b0;
        assert (grants == FrameLen)
            else valueError($sformatf("%0d credits granted in one pass", grants));
    endtask

    task automatic runCase(input int kind, input bit fast, input int expPeak,
                           input string name);
        int expCoarse;
        int expFine;
        int expCount;
        int expEst;
        int guard;
        buildFrame(kind);
        runModel(expCoarse, expFine, expCount, expEst);
        start = 1'b1;
        @(posedge clk);
        #10;
        start = 1'b0;
        // coarse pass, then fine pass on the same frame
        sendFrame(fast);
        sendFrame(fast);
        guard = 0;
        while (!resultValid) begin
            @(posedge clk);
            #10;
            guard++;
            if (guard > WaitLimit) stopRun("resultValid never arrived");
        end
        assert (peakCoarse == expCoarse) else valueError($sformatf(
            "%s: peakCoarse %0d, expected %0d", name, peakCoarse, expCoarse));
        assert (peakFine == expFine) else valueError($sformatf(
            "%s: peakFine %0d, expected %0d", name, peakFine, expFine));
        assert (peakCount == expCount) else valueError($sformatf(
            "%s: peakCount %0d, expected %0d", name, peakCount, expCount));
        assert (tsEstimate == expEst) else valueError($sformatf(
            "%s: tsEstimate %0d, expected %0d", name, tsEstimate, expEst));
        // fixed count for saturation and forwarding
        if (expPeak >= 0) begin
            assert (peakCount == expPeak) else valueError($sformatf(
                "%s: peakCount %0d, expected %0d", name, peakCount, expPeak));
        end
        @(posedge clk);
        #10;
        assert (!busy) else valueError($sformatf("%s: busy after result", name));
    endtask

    // busy must cover every grant and the result pulse
    always @(negedge clk) begin
        if (rstN) begin
            assert (!resultValid || busy) else valueError("resultValid without busy");
            assert (!creditOut || busy) else valueError("credit granted while idle");
        end
    end

    initial begin
        rngState = 32'hd2de;
        rstN = 1'b0;
        start = 1'b0;
        sampleValid = 1'b0;
        sample = '0;
        repeat (5) @(posedge clk);
        #10;
        rstN = 1'b1;
        // quiet until start
        repeat (4) begin
            @(posedge clk);
            #10;
            assert (!creditOut && !resultValid && !busy)
                else valueError("outputs active before start");
        end
        runCase(0, 1'b0, -1, "planted cluster");
        runCase(1, 1'b0, -1, "coarse tie");
        runCase(2, 1'b0, -1, "window clipped at zero");
        runCase(3, 1'b0, MaxCnt, "saturation");
        runCase(4, 1'b1, 20, "back-to-back hits");
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hdl
hdl/sifhPkg.sv
hdl/binMapper.sv
hdl/windowCalc.sv
hdl/histogramRam.sv
hdl/peakDetector.sv
hdl/hisBuilderFsm.sv
hdl/sifhTop.sv
bench/sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sifhPkg.sv
      - hdl/binMapper.sv
      - hdl/windowCalc.sv
      - hdl/histogramRam.sv
      - hdl/peakDetector.sv
      - hdl/hisBuilderFsm.sv
      - hdl/sifhTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/sifhTb.sv
